// ==== axi_uart_bus_pkg.sv ====
/*
  AXI4-Lite bus widths for the UART slave.
  Only OKAY is ever returned. SLVERR is kept for completeness of the code set.
*/
`default_nettype none

package axi_uart_bus_pkg;

  localparam int AXI_ADDR_WIDTH = 5;   // 32 bytes, eight word slots
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_LSB_WIDTH  = 2;   // byte offset, ignored by the decoder

  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

// ==== uart_map_pkg.sv ====
/*
  UART register map and field positions.
  Addresses are word indices, i.e. the bus address shifted right by two.
*/
`default_nettype none

package uart_map_pkg;

  localparam int UART_ADDR_WIDTH = 3;   // word index width
  localparam int UART_DATA_WIDTH = 8;
  localparam int UART_DIV_WIDTH  = 16;

  typedef enum logic [UART_ADDR_WIDTH-1:0] {
    UART_RBR_THR = 3'd0,   // rbr on read, thr on write
    UART_IER     = 3'd1,
    UART_DIV     = 3'd2,
    UART_LCR     = 3'd3,
    UART_LSR     = 3'd5
  } uart_reg_e;

  localparam int LCR_DLAB_BIT = 7;

  // line status fields
  localparam int LSR_DR_BIT   = 0;
  localparam int LSR_THRE_BIT = 5;
  localparam int LSR_TEMT_BIT = 6;

endpackage

`default_nettype wire

// ==== uart_fifo.sv ====
/*
  Synchronous byte FIFO, DEPTH a power of two.
  Push when full and pull when empty are ignored.
*/
`timescale 1ns/1ns
`default_nettype none

module uart_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  wire                                       fixed_clk_i,
  input  wire                                       axi_aresetn_i,
  input  wire                                       push_i,
  input  wire                                       pull_i,
  input  wire  [uart_map_pkg::UART_DATA_WIDTH-1:0]  data_i,
  output logic [uart_map_pkg::UART_DATA_WIDTH-1:0]  data_o,
  output logic                                      full_o,
  output logic                                      empty_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [uart_map_pkg::UART_DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]                         wr_ptr, rd_ptr;   // wrap naturally
  logic [PTR_W:0]                           count;
  logic                                     do_push, do_pull;

  assign full_o  = (count == DEPTH[PTR_W:0]);
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pull = pull_i && !empty_o;
  assign data_o  = mem[rd_ptr];   // oldest entry

  always_ff @(posedge fixed_clk_i) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pull) rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pull) count <= count + 1'b1;
      else if (do_pull && !do_push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/*
  8N1 serializer, each bit lasts baud_div_i cycles.
  One idle cycle separates back-to-back frames.
*/
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  wire                                       fixed_clk_i,
  input  wire                                       axi_aresetn_i,
  input  wire  [uart_map_pkg::UART_DIV_WIDTH-1:0]   baud_div_i,
  input  wire                                       fifo_empty_i,
  input  wire  [uart_map_pkg::UART_DATA_WIDTH-1:0]  fifo_data_i,
  output logic                                      fifo_pull_o,
  output logic                                      busy_o,
  output logic                                      uart_tx_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e                                state;
  logic [uart_map_pkg::UART_DIV_WIDTH-1:0]  baud_cnt;
  logic [2:0]                               bit_cnt;
  logic [uart_map_pkg::UART_DATA_WIDTH-1:0] shift;
  logic                                     bit_end;

  assign fifo_pull_o = (state == TX_IDLE) && !fifo_empty_i;
  assign busy_o      = (state != TX_IDLE);
  assign bit_end     = (baud_cnt == baud_div_i - 1'b1);

  always_ff @(posedge fixed_clk_i) begin
    if (fifo_pull_o) shift <= fifo_data_i;
    else if (bit_end && state == TX_DATA) shift <= shift >> 1;   // lsb first
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= TX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      uart_tx_o <= 1'b1;   // line idles high
    end else begin
      baud_cnt <= (state == TX_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE: if (fifo_pull_o) begin
          state     <= TX_START;
          uart_tx_o <= 1'b0;   // start bit
        end
        TX_START: if (bit_end) begin
          state     <= TX_DATA;
          bit_cnt   <= '0;
          uart_tx_o <= shift[0];
        end
        TX_DATA: if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            state     <= TX_STOP;
            uart_tx_o <= 1'b1;
          end else begin
            uart_tx_o <= shift[1];   // next bit before the shift lands
          end
        end
        default: if (bit_end) state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
/*
  8N1 receiver, samples mid-bit after a synchronized falling edge.
  Frames with a low stop bit are dropped.
*/
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  wire                                       fixed_clk_i,
  input  wire                                       axi_aresetn_i,
  input  wire  [uart_map_pkg::UART_DIV_WIDTH-1:0]   baud_div_i,
  input  wire                                       uart_rx_i,
  output logic                                      rx_push_o,
  output logic [uart_map_pkg::UART_DATA_WIDTH-1:0]  rx_data_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e                                state;
  logic                                     rx_meta, rx_sync;
  logic [uart_map_pkg::UART_DIV_WIDTH-1:0]  baud_cnt;
  logic [2:0]                               bit_cnt;
  logic                                     half_end, bit_end;

  assign half_end = (baud_cnt == (baud_div_i >> 1) - 1'b1);
  assign bit_end  = (baud_cnt == baud_div_i - 1'b1);

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= uart_rx_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (state == RX_DATA && bit_end) rx_data_o <= {rx_sync, rx_data_o[7:1]};
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= RX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      rx_push_o <= 1'b0;
    end else begin
      rx_push_o <= 1'b0;
      baud_cnt  <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rx_sync) state <= RX_START;
        end
        RX_START: if (half_end) begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          state    <= rx_sync ? RX_IDLE : RX_DATA;   // glitch, not a start bit
        end
        RX_DATA: if (bit_end) begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state <= RX_STOP;
        end
        default: if (bit_end) begin
          rx_push_o <= rx_sync;   // valid stop bit only
          state     <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== axi_lite_regs.sv ====
/*
  AXI4-Lite register block with independent write and read FSMs.
  THR/IER/RBR act only with DLAB clear, divisor writes only with DLAB set.
*/
`timescale 1ns/1ns
`default_nettype none

module axi_lite_regs #(
  parameter logic [uart_map_pkg::UART_DIV_WIDTH-1:0] DIV_RESET = 8
) (
  input  wire                                          fixed_clk_i,
  input  wire                                          axi_aresetn_i,
  input  wire  [axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:0]  axi_awaddr_i,
  input  wire                                          axi_awvalid_i,
  output logic                                         axi_awready_o,
  input  wire  [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0]  axi_wdata_i,
  input  wire                                          axi_wvalid_i,
  output logic                                         axi_wready_o,
  output axi_uart_bus_pkg::axi_resp_e                  axi_bresp_o,
  output logic                                         axi_bvalid_o,
  input  wire                                          axi_bready_i,
  input  wire  [axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:0]  axi_araddr_i,
  input  wire                                          axi_arvalid_i,
  output logic                                         axi_arready_o,
  output logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0]  axi_rdata_o,
  output axi_uart_bus_pkg::axi_resp_e                  axi_rresp_o,
  output logic                                         axi_rvalid_o,
  input  wire                                          axi_rready_i,
  input  wire                                          tx_full_i,
  input  wire                                          tx_empty_i,
  input  wire                                          tx_busy_i,
  input  wire                                          rx_empty_i,
  input  wire  [uart_map_pkg::UART_DATA_WIDTH-1:0]     rx_data_i,
  output logic                                         tx_push_o,
  output logic [uart_map_pkg::UART_DATA_WIDTH-1:0]     tx_data_o,
  output logic                                         rx_pull_o,
  output logic [uart_map_pkg::UART_DIV_WIDTH-1:0]      baud_div_o,
  output logic                                         read_interrupt_o
);

  typedef enum logic {W_IDLE, W_ACK} wr_state_e;
  typedef enum logic {R_IDLE, R_ACK} rd_state_e;

  wr_state_e                                   wr_state;
  rd_state_e                                   rd_state;
  logic [uart_map_pkg::UART_ADDR_WIDTH-1:0]    wr_word, rd_word;
  logic [uart_map_pkg::UART_DATA_WIDTH-1:0]    lcr_q, lsr_q;
  logic                                        ier_q;
  logic                                        dlab, wr_fire, rd_fire;
  logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] rd_data;

  assign wr_word = axi_awaddr_i[axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:axi_uart_bus_pkg::AXI_LSB_WIDTH];
  assign rd_word = axi_araddr_i[axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:axi_uart_bus_pkg::AXI_LSB_WIDTH];
  assign dlab    = lcr_q[uart_map_pkg::LCR_DLAB_BIT];

  // a thr write into a full fifo waits here until a byte leaves
  assign wr_fire = (wr_state == W_IDLE) && axi_awvalid_i && axi_wvalid_i &&
                   !(wr_word == uart_map_pkg::UART_RBR_THR && !dlab && tx_full_i);
  assign rd_fire = (rd_state == R_IDLE) && axi_arvalid_i;

  assign tx_push_o = wr_fire && (wr_word == uart_map_pkg::UART_RBR_THR) && !dlab;
  assign tx_data_o = axi_wdata_i[uart_map_pkg::UART_DATA_WIDTH-1:0];
  assign rx_pull_o = rd_fire && (rd_word == uart_map_pkg::UART_RBR_THR) && !dlab && !rx_empty_i;

  assign axi_bresp_o = axi_uart_bus_pkg::AXI_OKAY;
  assign axi_rresp_o = axi_uart_bus_pkg::AXI_OKAY;

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state      <= W_IDLE;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
      ier_q         <= 1'b0;
      lcr_q         <= '0;
      baud_div_o    <= DIV_RESET;
    end else if (wr_state == W_IDLE) begin
      if (wr_fire) begin
        wr_state      <= W_ACK;
        axi_awready_o <= 1'b1;
        axi_wready_o  <= 1'b1;
        axi_bvalid_o  <= 1'b1;
        case (wr_word)
          uart_map_pkg::UART_IER: if (!dlab) ier_q <= axi_wdata_i[0];
          uart_map_pkg::UART_DIV: begin
            if (dlab) baud_div_o <= axi_wdata_i[uart_map_pkg::UART_DIV_WIDTH-1:0];
          end
          uart_map_pkg::UART_LCR: lcr_q <= axi_wdata_i[uart_map_pkg::UART_DATA_WIDTH-1:0];
          default: ;   // thr pushes directly, others are dropped
        endcase
      end
    end else begin
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      if (axi_bready_i) begin   // hold response until taken
        axi_bvalid_o <= 1'b0;
        wr_state     <= W_IDLE;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (rd_word)
      uart_map_pkg::UART_RBR_THR: begin
        if (!dlab && !rx_empty_i) rd_data[uart_map_pkg::UART_DATA_WIDTH-1:0] = rx_data_i;
      end
      uart_map_pkg::UART_IER: rd_data[0] = ier_q;
      uart_map_pkg::UART_DIV: rd_data[uart_map_pkg::UART_DIV_WIDTH-1:0] = baud_div_o;
      uart_map_pkg::UART_LCR: rd_data[uart_map_pkg::UART_DATA_WIDTH-1:0] = lcr_q;
      uart_map_pkg::UART_LSR: rd_data[uart_map_pkg::UART_DATA_WIDTH-1:0] = lsr_q;
      default: ;   // unmapped reads give zero
    endcase
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state      <= R_IDLE;
      axi_arready_o <= 1'b0;
      axi_rvalid_o  <= 1'b0;
    end else if (rd_state == R_IDLE) begin
      if (rd_fire) begin
        rd_state      <= R_ACK;
        axi_arready_o <= 1'b1;
        axi_rvalid_o  <= 1'b1;
      end
    end else begin
      axi_arready_o <= 1'b0;
      if (axi_rready_i) begin
        axi_rvalid_o <= 1'b0;
        rd_state     <= R_IDLE;
      end
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (rd_fire) axi_rdata_o <= rd_data;   // stays stable while rvalid waits
  end

  // status and interrupt trail the fifo flags by one cycle
  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      lsr_q            <= '0;
      read_interrupt_o <= 1'b0;
    end else begin
      lsr_q                             <= '0;
      lsr_q[uart_map_pkg::LSR_DR_BIT]   <= !rx_empty_i;
      lsr_q[uart_map_pkg::LSR_THRE_BIT] <= !tx_full_i;
      lsr_q[uart_map_pkg::LSR_TEMT_BIT] <= tx_empty_i && !tx_busy_i;
      read_interrupt_o                  <= !rx_empty_i && ier_q;
    end
  end

endmodule

`default_nettype wire

// ==== axi_uart_top.sv ====
/*
  AXI4-Lite UART slave, 8N1 only, single clock.
  FIFO_DEPTH must be a power of two; the baud divisor must be at least 2.
*/
`timescale 1ns/1ns
`default_nettype none

module axi_uart_top #(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter logic [uart_map_pkg::UART_DIV_WIDTH-1:0] DIV_RESET = 8
) (
  input  wire                                          fixed_clk_i,
  input  wire                                          axi_aresetn_i,
  input  wire  [axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:0]  axi_awaddr_i,
  input  wire                                          axi_awvalid_i,
  output logic                                         axi_awready_o,
  input  wire  [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0]  axi_wdata_i,
  input  wire                                          axi_wvalid_i,
  output logic                                         axi_wready_o,
  output axi_uart_bus_pkg::axi_resp_e                  axi_bresp_o,
  output logic                                         axi_bvalid_o,
  input  wire                                          axi_bready_i,
  input  wire  [axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:0]  axi_araddr_i,
  input  wire                                          axi_arvalid_i,
  output logic                                         axi_arready_o,
  output logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0]  axi_rdata_o,
  output axi_uart_bus_pkg::axi_resp_e                  axi_rresp_o,
  output logic                                         axi_rvalid_o,
  input  wire                                          axi_rready_i,
  output logic                                         read_interrupt_o,
  input  wire                                          uart_rx_i,
  output logic                                         uart_tx_o
);

  logic                                        tx_push, tx_pull, tx_full, tx_empty, tx_busy;
  logic                                        rx_push, rx_pull, rx_empty;
  logic [uart_map_pkg::UART_DATA_WIDTH-1:0]    tx_wdata, tx_rdata;   // bus side, serial side
  logic [uart_map_pkg::UART_DATA_WIDTH-1:0]    rx_wdata, rx_rdata;
  logic [uart_map_pkg::UART_DIV_WIDTH-1:0]     baud_div;

  axi_lite_regs #(.DIV_RESET(DIV_RESET)) regs (
    .fixed_clk_i, .axi_aresetn_i,
    .axi_awaddr_i, .axi_awvalid_i, .axi_awready_o,
    .axi_wdata_i, .axi_wvalid_i, .axi_wready_o,
    .axi_bresp_o, .axi_bvalid_o, .axi_bready_i,
    .axi_araddr_i, .axi_arvalid_i, .axi_arready_o,
    .axi_rdata_o, .axi_rresp_o, .axi_rvalid_o, .axi_rready_i,
    .tx_full_i(tx_full), .tx_empty_i(tx_empty), .tx_busy_i(tx_busy),
    .rx_empty_i(rx_empty), .rx_data_i(rx_rdata),
    .tx_push_o(tx_push), .tx_data_o(tx_wdata), .rx_pull_o(rx_pull),
    .baud_div_o(baud_div), .read_interrupt_o
  );

  uart_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo (
    .fixed_clk_i, .axi_aresetn_i,
    .push_i(tx_push), .pull_i(tx_pull), .data_i(tx_wdata),
    .data_o(tx_rdata), .full_o(tx_full), .empty_o(tx_empty)
  );

  uart_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo (
    .fixed_clk_i, .axi_aresetn_i,
    .push_i(rx_push), .pull_i(rx_pull), .data_i(rx_wdata),
    .data_o(rx_rdata), .full_o(), .empty_o(rx_empty)   // overflow bytes dropped inside
  );

  uart_tx tx (
    .fixed_clk_i, .axi_aresetn_i, .baud_div_i(baud_div),
    .fifo_empty_i(tx_empty), .fifo_data_i(tx_rdata),
    .fifo_pull_o(tx_pull), .busy_o(tx_busy), .uart_tx_o
  );

  uart_rx rx (
    .fixed_clk_i, .axi_aresetn_i, .baud_div_i(baud_div), .uart_rx_i,
    .rx_push_o(rx_push), .rx_data_o(rx_wdata)
  );

endmodule

`default_nettype wire

// ==== tb_axi_uart_assert.sv ====
/*
  Bus handshake checks, bound into axi_lite_regs.
  All checks are disabled while reset is asserted.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_axi_uart_assert (
  input wire fixed_clk_i,
  input wire axi_aresetn_i,
  input wire axi_awvalid_i,
  input wire axi_awready_o,
  input wire axi_bvalid_o,
  input wire axi_bready_i,
  input wire axi_rvalid_o,
  input wire axi_rready_i
);

  int unsigned fail_count = 0;   // read by the testbench at the end

  bvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    axi_bvalid_o && !axi_bready_i |=> axi_bvalid_o)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  rvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    axi_rvalid_o && !axi_rready_i |=> axi_rvalid_o)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  awready_needs_awvalid: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    $rose(axi_awready_o) |-> $past(axi_awvalid_i))
    else begin
      fail_count++;
      $error("awready rose without awvalid");
    end

endmodule

bind axi_lite_regs tb_axi_uart_assert chk (
  .fixed_clk_i(fixed_clk_i),
  .axi_aresetn_i(axi_aresetn_i),
  .axi_awvalid_i(axi_awvalid_i),
  .axi_awready_o(axi_awready_o),
  .axi_bvalid_o(axi_bvalid_o),
  .axi_bready_i(axi_bready_i),
  .axi_rvalid_o(axi_rvalid_o),
  .axi_rready_i(axi_rready_i)
);

`default_nettype wire

// ==== tb_axi_uart.sv ====
/*
  Testbench for axi_uart_top, driven by axi_uart_tests.txt from the project root.
  Inputs change on the rising edge, outputs are sampled on the falling edge.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_axi_uart;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam logic [uart_map_pkg::UART_DIV_WIDTH-1:0] DIV_RESET = 16'd8;
  localparam int TIMEOUT = 2000;   // cycles per wait

  logic                                        fixed_clk;
  logic                                        axi_aresetn;
  logic [axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:0] awaddr;
  logic                                        awvalid;
  logic                                        awready;
  logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] wdata;
  logic                                        wvalid;
  logic                                        wready;
  axi_uart_bus_pkg::axi_resp_e                 bresp;
  logic                                        bvalid;
  logic                                        bready;
  logic [axi_uart_bus_pkg::AXI_ADDR_WIDTH-1:0] araddr;
  logic                                        arvalid;
  logic                                        arready;
  logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] rdata;
  axi_uart_bus_pkg::axi_resp_e                 rresp;
  logic                                        rvalid;
  logic                                        rready;
  logic                                        read_interrupt;
  logic                                        uart_tx;
  logic                                        uart_rx;
  logic                                        loopback;
  logic                                        dlab;      // expected LCR DLAB
  int                                          cur_div;   // expected divisor

  assign uart_rx = loopback ? uart_tx : 1'b1;

  axi_uart_top #(.FIFO_DEPTH(FIFO_DEPTH), .DIV_RESET(DIV_RESET)) uut (
    .fixed_clk_i(fixed_clk), .axi_aresetn_i(axi_aresetn),
    .axi_awaddr_i(awaddr), .axi_awvalid_i(awvalid), .axi_awready_o(awready),
    .axi_wdata_i(wdata), .axi_wvalid_i(wvalid), .axi_wready_o(wready),
    .axi_bresp_o(bresp), .axi_bvalid_o(bvalid), .axi_bready_i(bready),
    .axi_araddr_i(araddr), .axi_arvalid_i(arvalid), .axi_arready_o(arready),
    .axi_rdata_o(rdata), .axi_rresp_o(rresp), .axi_rvalid_o(rvalid), .axi_rready_i(rready),
    .read_interrupt_o(read_interrupt), .uart_rx_i(uart_rx), .uart_tx_o(uart_tx)
  );

  initial begin
    fixed_clk = 1'b0;
    forever #20 fixed_clk = ~fixed_clk;
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input string name,
                            input logic [uart_map_pkg::UART_DATA_WIDTH-1:0] exp,
                            input logic [uart_map_pkg::UART_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name,
                            input logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] exp,
                            input logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input axi_uart_bus_pkg::axi_resp_e exp,
                            input axi_uart_bus_pkg::axi_resp_e act);
    if (act !== exp) begin
      $display("error: %s expected %s actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic axi_write(input string name, input uart_map_pkg::uart_reg_e word,
                           input logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] data,
                           output axi_uart_bus_pkg::axi_resp_e resp);
    int cycles;
    cycles = 0;
    @(posedge fixed_clk);
    awaddr  <= {word, {axi_uart_bus_pkg::AXI_LSB_WIDTH{1'b0}}};
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    do begin
      @(negedge fixed_clk);
      cycles = cycles + 1;
      if (cycles > TIMEOUT) report_timeout("awready on a write");
    end while (awready !== 1'b1);
    check_bit($sformatf("%s_wready_with_awready", name), 1'b1, wready);
    check_bit($sformatf("%s_bvalid_with_awready", name), 1'b1, bvalid);
    resp = bresp;
    @(posedge fixed_clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;   // one cycle late, so bvalid has to hold
    cycles = 0;
    do begin
      @(negedge fixed_clk);
      cycles = cycles + 1;
      if (cycles > TIMEOUT) report_timeout("bvalid to drop after bready");
    end while (bvalid !== 1'b0);
    @(posedge fixed_clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input string name, input uart_map_pkg::uart_reg_e word,
                          output logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] data,
                          output axi_uart_bus_pkg::axi_resp_e resp);
    int cycles;
    cycles = 0;
    @(posedge fixed_clk);
    araddr  <= {word, {axi_uart_bus_pkg::AXI_LSB_WIDTH{1'b0}}};
    arvalid <= 1'b1;
    do begin
      @(negedge fixed_clk);
      cycles = cycles + 1;
      if (cycles > TIMEOUT) report_timeout("arready on a read");
    end while (arready !== 1'b1);
    check_bit($sformatf("%s_rvalid_with_arready", name), 1'b1, rvalid);
    data = rdata;
    resp = rresp;
    @(posedge fixed_clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    cycles = 0;
    do begin
      @(negedge fixed_clk);
      cycles = cycles + 1;
      if (cycles > TIMEOUT) report_timeout("rvalid to drop after rready");
    end while (rvalid !== 1'b0);
    @(posedge fixed_clk);
    rready <= 1'b0;
  endtask

  // samples each bit near its middle, div cycles apart
  task automatic serial_decode(input int div,
                               output logic [uart_map_pkg::UART_DATA_WIDTH-1:0] data);
    int cycles;
    cycles = 0;
    data = '0;
    do begin
      @(negedge fixed_clk);
      cycles = cycles + 1;
      if (cycles > TIMEOUT) report_timeout("a start bit on uart_tx_o");
    end while (uart_tx !== 1'b0);
    repeat (div / 2) @(negedge fixed_clk);
    if (uart_tx !== 1'b0) begin
      $display("start bit on uart_tx_o did not last to its middle");
      abort_run();
    end
    for (int i = 0; i < uart_map_pkg::UART_DATA_WIDTH; i++) begin
      repeat (div) @(negedge fixed_clk);
      data[i] = uart_tx;   // lsb first
    end
    repeat (div) @(negedge fixed_clk);
    if (uart_tx !== 1'b1) begin
      $display("stop bit on uart_tx_o was not high");
      abort_run();
    end
  endtask

  task automatic write_register(input string name, input uart_map_pkg::uart_reg_e word,
                                input logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] data);
    axi_uart_bus_pkg::axi_resp_e resp;
    axi_write(name, word, data, resp);
    check_resp(name, axi_uart_bus_pkg::AXI_OKAY, resp);
  endtask

  task automatic read_register(input string name, input uart_map_pkg::uart_reg_e word,
                               input logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] exp);
    axi_uart_bus_pkg::axi_resp_e               resp;
    logic [axi_uart_bus_pkg::AXI_DATA_WIDTH-1:0] data;
    axi_read(name, word, data, resp);
    check_word(name, exp, data);
    check_resp(name, axi_uart_bus_pkg::AXI_OKAY, resp);
  endtask

  // back-to-back thr writes while a second branch decodes the line
  task automatic thr_burst(input string name, input logic [7:0] first);
    logic [uart_map_pkg::UART_DATA_WIDTH-1:0] got;
    fork
      begin
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
          write_register($sformatf("%s_wr_%0d", name, i), uart_map_pkg::UART_RBR_THR,
                         {24'h0, first + 8'(i)});
        end
      end
      begin
        for (int j = 0; j < FIFO_DEPTH + 2; j++) begin
          serial_decode(cur_div, got);
          check_data($sformatf("%s_frame_%0d", name, j), first + 8'(j), got);
        end
      end
    join
  endtask

  task automatic run_test(input string name, input string op,
                          input logic [31:0] operand, input logic [31:0] expected);
    logic [uart_map_pkg::UART_DATA_WIDTH-1:0] got;
    int                                       cycles;
    cycles = 0;
    case (op)
      "loop": begin
        @(posedge fixed_clk);
        loopback <= operand[0];
      end
      "wr_thr": write_register(name, uart_map_pkg::UART_RBR_THR, operand);
      "wr_ier": write_register(name, uart_map_pkg::UART_IER, operand);
      "wr_div": begin
        write_register(name, uart_map_pkg::UART_DIV, operand);
        if (dlab) cur_div = int'(operand[15:0]);   // only with DLAB set
      end
      "wr_lcr": begin
        write_register(name, uart_map_pkg::UART_LCR, operand);
        dlab = operand[uart_map_pkg::LCR_DLAB_BIT];
      end
      "rd_rbr": read_register(name, uart_map_pkg::UART_RBR_THR, expected);
      "rd_ier": read_register(name, uart_map_pkg::UART_IER, expected);
      "rd_div": read_register(name, uart_map_pkg::UART_DIV, expected);
      "rd_lsr": read_register(name, uart_map_pkg::UART_LSR, expected);
      "tx": begin
        fork
          write_register(name, uart_map_pkg::UART_RBR_THR, operand);
          serial_decode(cur_div, got);   // watches the line from before the push
        join
        check_data(name, expected[7:0], got);
        repeat (cur_div + 4) @(negedge fixed_clk);   // end of stop bit and rx push
      end
      "silent": begin
        repeat (int'(operand)) begin
          @(negedge fixed_clk);
          check_bit(name, 1'b1, uart_tx);
        end
      end
      "irq": begin
        do begin
          @(negedge fixed_clk);
          cycles = cycles + 1;
          if (cycles > int'(operand)) begin
            $display("read_interrupt_o did not settle at %0d in test %s", expected[0], name);
            abort_run();
          end
        end while (read_interrupt !== expected[0]);
      end
      "burst": thr_burst(name, operand[7:0]);
      default: begin
        $display("unknown operation %s in test %s", op, name);
        abort_run();
      end
    endcase
  endtask

  initial begin
    string       line;
    string       name;
    string       op;
    logic [31:0] operand;
    logic [31:0] expected;
    int          fd;
    int          fields;
    axi_aresetn = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    loopback    = 1'b0;
    dlab        = 1'b0;
    cur_div     = int'(DIV_RESET);
    repeat (5) @(posedge fixed_clk);
    axi_aresetn <= 1'b1;
    @(negedge fixed_clk);
    check_bit("reset_awready", 1'b0, awready);
    check_bit("reset_wready", 1'b0, wready);
    check_bit("reset_bvalid", 1'b0, bvalid);
    check_bit("reset_arready", 1'b0, arready);
    check_bit("reset_rvalid", 1'b0, rvalid);
    check_bit("reset_interrupt", 1'b0, read_interrupt);
    check_bit("reset_uart_tx", 1'b1, uart_tx);
    fd = $fopen("axi_uart_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test file axi_uart_tests.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      fields = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin   // skip blank and comment lines
        fields = $sscanf(line, "%s %s %h %h", name, op, operand, expected);
        if (fields != 4) begin
          $display("malformed line in the test file: %s", line);
          abort_run();
        end
        run_test(name, op, operand, expected);
      end
    end
    $fclose(fd);
    if (uut.regs.chk.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d bus handshake assertions failed", uut.regs.chk.fail_count);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== axi_uart_tests.txt ====
# columns: test name, operation, operand (hex), expected value (hex)
# tx: operand is the THR byte, expected the decoded byte; irq: operand is a cycle limit
reset_lsr       rd_lsr  0   60
reset_div       rd_div  0   8
tx_a5           tx      a5  a5
tx_3c           tx      3c  3c
loop_on         loop    1   0
rx_41           tx      41  41
rx_42           tx      42  42
rx_43           tx      43  43
rx_lsr_ready    rd_lsr  0   61
rx_read_41      rd_rbr  0   41
rx_read_42      rd_rbr  0   42
rx_read_43      rd_rbr  0   43
rx_read_empty   rd_rbr  0   0
rx_lsr_empty    rd_lsr  0   60
loop_off        loop    0   0
div_gated       wr_div  4   0
div_unchanged   rd_div  0   8
dlab_set        wr_lcr  80  0
thr_gated       wr_thr  5a  0
no_frame        silent  c8  0
div_write       wr_div  6   0
div_readback    rd_div  0   6
dlab_clear      wr_lcr  0   0
tx_new_div      tx      c3  c3
irq_loop_on     loop    1   0
ier_set         wr_ier  1   0
ier_readback    rd_ier  0   1
irq_byte        tx      11  11
irq_high        irq     40  1
irq_read        rd_rbr  0   11
irq_low         irq     40  0
ier_clear       wr_ier  0   0
quiet_byte      tx      22  22
quiet_lsr       rd_lsr  0   61
quiet_irq       irq     8   0
quiet_read      rd_rbr  0   22
burst_loop_off  loop    0   0
burst_six       burst   80  0

// ==== axi_uart.f ====
axi_uart_bus_pkg.sv
uart_map_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
axi_lite_regs.sv
axi_uart_top.sv
tb_axi_uart_assert.sv
tb_axi_uart.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_uart -f axi_uart.f
./obj_dir/Vtb_axi_uart > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
